//--- Makefile
VERILATOR ?= verilator
TOP       := tmr_tb
FILELIST  := all.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
SIM_ARGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG); grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
common/tmr_pkg.sv
logic/tmr_voter.sv
logic/tmr_mismatch_cnt.sv
tmr_ctrl/tmr_ctrl_regs.sv
tmr_ctrl/tmr_ctrl_fsm.sv
logic/tmr_subsys_top.sv
testbench/tmr_assert.sv
testbench/tmr_tb.sv

//--- common/tmr_pkg.sv
/*
 * TMR control subsystem package
 * Register bus, configuration, core payload and controller mode types,
 * together with the register map of the control block.
 */
`default_nettype none

package tmr_pkg;

  // Register bus request, one cycle with valid high
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  // Read data returns in the same cycle as the request
  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  // Configuration as seen by the mode controller
  typedef struct packed {
    logic enable;
    logic delay_resynch;
    logic setback;
    logic reload_setback;
    logic rapid_recovery;
    logic force_resynch;
  } tmr_cfg_t;

  // Observable output bundle of one core
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] data;
  } core_out_t;

  typedef enum logic [2:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD,
    TMR_RAPID
  } tmr_mode_e;

  // Register map
  localparam logic [7:0] ADDR_ENABLE    = 8'h00;
  localparam logic [7:0] ADDR_CONFIG    = 8'h04;
  localparam logic [7:0] ADDR_MISMATCH0 = 8'h08;
  localparam logic [7:0] ADDR_MISMATCH1 = 8'h0C;
  localparam logic [7:0] ADDR_MISMATCH2 = 8'h10;

  // Bit positions inside ADDR_CONFIG
  localparam int unsigned CFG_DELAY_RESYNCH  = 0;
  localparam int unsigned CFG_SETBACK        = 1;
  localparam int unsigned CFG_RELOAD_SETBACK = 2;
  localparam int unsigned CFG_RAPID_RECOVERY = 3;
  localparam int unsigned CFG_FORCE_RESYNCH  = 4;

endpackage

`default_nettype wire

//--- logic/tmr_mismatch_cnt.sv
/*
 * Mismatch counters
 * One saturating counter per core, counting the cycles in which that core
 * disagreed with the vote. Software clears each counter on its own.
 */
`default_nettype none

module tmr_mismatch_cnt #(
  parameter int CntWidth = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [2:0]               incr_i,
  input  logic [2:0]               clr_i,
  output logic [2:0][CntWidth-1:0] cnt_o
);

  logic [2:0][CntWidth-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int k = 0; k < 3; k++) begin
        // Clear takes priority over a count in the same cycle
        if (clr_i[k]) begin
          cnt_q[k] <= '0;
        end else if (incr_i[k] && (cnt_q[k] != {CntWidth{1'b1}})) begin
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

  assign cnt_o = cnt_q;

endmodule

`default_nettype wire

//--- logic/tmr_subsys_top.sv
/*
 * TMR control subsystem
 * Ties together the control registers, mode controller, majority voter
 * and mismatch counters for one group of three lockstep cores.
 */
`default_nettype none

module tmr_subsys_top #(
  parameter bit TmrFixed        = 1'b0,
  parameter bit RapidRecoveryEn = 1'b1,
  parameter int CntWidth        = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tmr_pkg::reg_req_t  reg_req_i,
  output tmr_pkg::reg_rsp_t  reg_rsp_o,
  input  tmr_pkg::core_out_t core_out_i [3],
  output tmr_pkg::core_out_t voted_o,
  input  logic               sp_store_is_zero_i,
  input  logic               sp_store_will_be_zero_i,
  input  logic               fetch_en_i,
  input  logic               cores_synch_i,
  input  logic               recovery_finished_i,
  output logic [2:0]         setback_o,
  output logic               sw_synch_req_o,
  output logic               sw_resynch_req_o,
  output logic               grp_in_independent_o,
  output logic               rapid_recovery_en_o,
  output logic               recovery_request_o
);
  import tmr_pkg::*;

  tmr_cfg_t                 cfg;
  logic                     force_ack;
  logic [2:0]               clr;
  logic [2:0]               incr;
  logic [2:0][CntWidth-1:0] cnt;
  logic [2:0]               error;
  logic                     single_mismatch;
  logic                     failure;

  tmr_ctrl_regs #(
    .TmrFixed       (TmrFixed),
    .RapidRecoveryEn(RapidRecoveryEn),
    .CntWidth       (CntWidth)
  ) i_tmr_ctrl_regs (
    .clk_i,
    .rst_ni,
    .reg_req_i,
    .reg_rsp_o,
    .cnt_i      (cnt),
    .force_ack_i(force_ack),
    .cfg_o      (cfg),
    .clr_o      (clr)
  );

  tmr_ctrl_fsm #(
    .TmrFixed       (TmrFixed),
    .RapidRecoveryEn(RapidRecoveryEn)
  ) i_tmr_ctrl_fsm (
    .clk_i,
    .rst_ni,
    .cfg_i                  (cfg),
    .single_mismatch_i      (single_mismatch),
    .failure_i              (failure),
    .error_i                (error),
    .sp_store_is_zero_i,
    .sp_store_will_be_zero_i,
    .fetch_en_i,
    .cores_synch_i,
    .recovery_finished_i,
    .setback_o,
    .sw_synch_req_o,
    .sw_resynch_req_o,
    .grp_in_independent_o,
    .rapid_recovery_en_o,
    .incr_o                 (incr),
    .recovery_request_o,
    .force_ack_o            (force_ack)
  );

  tmr_voter i_tmr_voter (
    .core_out_i,
    .voted_o,
    .error_o          (error),
    .single_mismatch_o(single_mismatch),
    .failure_o        (failure)
  );

  tmr_mismatch_cnt #(
    .CntWidth(CntWidth)
  ) i_tmr_mismatch_cnt (
    .clk_i,
    .rst_ni,
    .incr_i(incr),
    .clr_i (clr),
    .cnt_o (cnt)
  );

endmodule

`default_nettype wire

//--- logic/tmr_voter.sv
/*
 * TMR majority voter
 * Bitwise two-out-of-three vote over the output bundles of three cores,
 * flagging each core that disagrees and a total failure.
 */
`default_nettype none

module tmr_voter (
  input  tmr_pkg::core_out_t core_out_i [3],
  output tmr_pkg::core_out_t voted_o,
  output logic [2:0]         error_o,
  output logic               single_mismatch_o,
  output logic               failure_o
);
  import tmr_pkg::*;

  core_out_t majority;
  logic      diff_01;
  logic      diff_02;
  logic      diff_12;

  // Each bit takes the value held by at least two cores
  assign majority = core_out_t'((core_out_i[0] & core_out_i[1]) |
                                (core_out_i[0] & core_out_i[2]) |
                                (core_out_i[1] & core_out_i[2]));

  assign voted_o = majority;

  always_comb begin
    for (int k = 0; k < 3; k++) begin
      error_o[k] = (core_out_i[k] != majority);
    end
  end

  assign diff_01 = (core_out_i[0] != core_out_i[1]);
  assign diff_02 = (core_out_i[0] != core_out_i[2]);
  assign diff_12 = (core_out_i[1] != core_out_i[2]);

  // No pair agrees, so the vote cannot be trusted
  assign failure_o = diff_01 & diff_02 & diff_12;

  assign single_mismatch_o = $onehot(error_o) & ~failure_o;

endmodule

`default_nettype wire

//--- testbench/tmr_assert.sv
/*
 * TMR control assertions
 * Concurrent properties on the outputs of the subsystem top level,
 * bound into tmr_subsys_top from the testbench.
 */
`default_nettype none

module tmr_assert (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       sw_synch_req_i,
  input logic       sw_resynch_req_i,
  input logic       recovery_request_i,
  input logic       rapid_recovery_en_i,
  input logic [2:0] setback_i
);

  int unsigned fail_cnt = 0;

  // Requests are single cycle pulses
  assert property (@(posedge clk_i) disable iff (!rst_ni) sw_synch_req_i |=> !sw_synch_req_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("synch request high for two cycles");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   sw_resynch_req_i |=> !sw_resynch_req_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("resynch request high for two cycles");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   recovery_request_i |-> rapid_recovery_en_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("recovery request without rapid recovery");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   setback_i inside {3'b000, 3'b110, 3'b111})
    else begin
      fail_cnt = fail_cnt + 1;
      $error("illegal setback pattern");
    end

endmodule

`default_nettype wire

//--- testbench/tmr_tb.sv
/*
 * Testbench for the TMR control subsystem
 * Walks the core group through enable, voting and counting, rapid
 * recovery, unload and reload, leaving and re-entering lockstep and a
 * forced resynchronization. Bound assertions watch the control outputs.
 */
`default_nettype none

module tmr_tb;
  import tmr_pkg::*;

  localparam int CntWidth = 8;
  localparam int Timeout  = 50;

  localparam int WaitSynchReq    = 0;
  localparam int WaitResynchReq  = 1;
  localparam int WaitRecoveryReq = 2;
  localparam int WaitLockstep    = 3;

  logic        clk_i;
  logic        rst_ni;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  core_out_t   core_out [3];
  core_out_t   voted;
  logic        sp_store_is_zero;
  logic        sp_store_will_be_zero;
  logic        fetch_en;
  logic        cores_synch;
  logic        recovery_finished;
  logic [2:0]  setback;
  logic        sw_synch_req;
  logic        sw_resynch_req;
  logic        grp_in_independent;
  logic        rapid_recovery_en;
  logic        recovery_request;
  logic [31:0] rng_state;
  int          exp_cnt [3];
  int          k;
  core_out_t   idle_payload;

  tmr_subsys_top #(
    .TmrFixed       (1'b0),
    .RapidRecoveryEn(1'b1),
    .CntWidth       (CntWidth)
  ) i_tmr_subsys_top (
    .clk_i,
    .rst_ni,
    .reg_req_i              (reg_req),
    .reg_rsp_o              (reg_rsp),
    .core_out_i             (core_out),
    .voted_o                (voted),
    .sp_store_is_zero_i     (sp_store_is_zero),
    .sp_store_will_be_zero_i(sp_store_will_be_zero),
    .fetch_en_i             (fetch_en),
    .cores_synch_i          (cores_synch),
    .recovery_finished_i    (recovery_finished),
    .setback_o              (setback),
    .sw_synch_req_o         (sw_synch_req),
    .sw_resynch_req_o       (sw_resynch_req),
    .grp_in_independent_o   (grp_in_independent),
    .rapid_recovery_en_o    (rapid_recovery_en),
    .recovery_request_o     (recovery_request)
  );

  bind tmr_subsys_top tmr_assert i_tmr_assert (
    .clk_i,
    .rst_ni,
    .sw_synch_req_i     (sw_synch_req_o),
    .sw_resynch_req_i   (sw_resynch_req_o),
    .recovery_request_i (recovery_request_o),
    .rapid_recovery_en_i(rapid_recovery_en_o),
    .setback_i          (setback_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [65:0] act, input logic [65:0] exp);
    assert (act === exp) else begin
      $display("ERR time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, name, exp, act);
      abort_run("Stopping at the first error");
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic core_out_t rand_payload();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = rand32();
    b = rand32();
    c = rand32();
    return core_out_t'({c[1:0], a, b});
  endfunction

  function automatic logic [7:0] cnt_addr(input int core);
    case (core)
      0:       return ADDR_MISMATCH0;
      1:       return ADDR_MISMATCH1;
      default: return ADDR_MISMATCH2;
    endcase
  endfunction

  function automatic logic cond_met(input int sel);
    case (sel)
      WaitSynchReq:    return sw_synch_req;
      WaitResynchReq:  return sw_resynch_req;
      WaitRecoveryReq: return recovery_request;
      default:         return ~grp_in_independent;
    endcase
  endfunction

  // Polls once per cycle in the low clock phase
  task automatic wait_until(input int sel, input string what);
    int n;
    n = 0;
    #1;
    while (!cond_met(sel)) begin
      n++;
      if (n > Timeout) begin
        abort_run({"Timeout while waiting for ", what});
      end
      @(negedge clk_i);
      #1;
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    @(negedge clk_i);
    reg_req = '0;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp,
                            input logic exp_err, input string name);
    @(negedge clk_i);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.addr  = addr;
    reg_req.wdata = '0;
    #1;
    check_eq("reg_rsp_o.error", reg_rsp.error, exp_err);
    check_eq(name, reg_rsp.rdata, exp);
    @(negedge clk_i);
    reg_req = '0;
  endtask

  // One cycle with a single core's bundle flipped by a nonzero mask
  task automatic inject_mismatch(input int core);
    core_out_t p;
    core_out_t m;
    p = rand_payload();
    m = rand_payload();
    while (m == '0) begin
      m = rand_payload();
    end
    @(negedge clk_i);
    for (int j = 0; j < 3; j++) begin
      core_out[j] = (j == core) ? core_out_t'(p ^ m) : p;
    end
    #1;
    check_eq("voted_o", voted, p);
    @(negedge clk_i);
    for (int j = 0; j < 3; j++) begin
      core_out[j] = p;
    end
  endtask

  always @(negedge clk_i) begin
    if (i_tmr_subsys_top.i_tmr_assert.fail_cnt != 0) begin
      abort_run("A bound assertion on the top level failed");
    end
  end

  initial begin
    rng_state             = 32'd55208;
    exp_cnt               = '{0, 0, 0};
    rst_ni                = 1'b0;
    reg_req               = '0;
    sp_store_is_zero      = 1'b1;
    sp_store_will_be_zero = 1'b0;
    fetch_en              = 1'b0;
    cores_synch           = 1'b0;
    recovery_finished     = 1'b0;
    idle_payload          = rand_payload();
    for (int j = 0; j < 3; j++) begin
      core_out[j] = idle_payload;
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset state, then enable while the cores do not fetch
    @(negedge clk_i);
    #1;
    check_eq("grp_in_independent_o", grp_in_independent, 1'b1);
    check_eq("setback_o", setback, 3'b000);
    check_eq("sw_synch_req_o", sw_synch_req, 1'b0);
    check_eq("sw_resynch_req_o", sw_resynch_req, 1'b0);
    check_eq("recovery_request_o", recovery_request, 1'b0);
    check_eq("reg_rsp_o.error", reg_rsp.error, 1'b0);
    write_reg(ADDR_ENABLE, 32'h1);
    #1;
    check_eq("grp_in_independent_o", grp_in_independent, 1'b1);
    @(negedge clk_i);
    #1;
    check_eq("grp_in_independent_o", grp_in_independent, 1'b0);
    read_check(ADDR_ENABLE, 32'h1, 1'b0, "enable register");
    @(negedge clk_i);
    fetch_en = 1'b1;

    // Voting and counting with resynch delayed
    write_reg(ADDR_CONFIG, 32'h1);
    k = int'(rand32() % 32'd3);
    for (int i = 0; i < 3; i++) begin
      inject_mismatch(k);
      exp_cnt[k]++;
      read_check(cnt_addr(k), exp_cnt[k], 1'b0, "mismatch counter");
    end
    read_check(cnt_addr((k + 1) % 3), exp_cnt[(k + 1) % 3], 1'b0, "mismatch counter");
    write_reg(cnt_addr(k), 32'hFFFF_FFFF);
    exp_cnt[k] = 0;
    read_check(cnt_addr(k), 32'd0, 1'b0, "mismatch counter");

    // Rapid recovery
    write_reg(ADDR_CONFIG, 32'h8);
    #1;
    check_eq("rapid_recovery_en_o", rapid_recovery_en, 1'b1);
    k = int'(rand32() % 32'd3);
    inject_mismatch(k);
    exp_cnt[k]++;
    wait_until(WaitRecoveryReq, "recovery_request_o");
    repeat (3) begin
      @(negedge clk_i);
      #1;
      check_eq("recovery_request_o", recovery_request, 1'b1);
      check_eq("grp_in_independent_o", grp_in_independent, 1'b0);
    end
    @(negedge clk_i);
    recovery_finished = 1'b1;
    @(negedge clk_i);
    recovery_finished = 1'b0;
    #1;
    check_eq("recovery_request_o", recovery_request, 1'b0);
    check_eq("grp_in_independent_o", grp_in_independent, 1'b0);
    read_check(cnt_addr(k), exp_cnt[k], 1'b0, "mismatch counter");

    // Unload and reload with setback
    write_reg(ADDR_CONFIG, 32'h2);
    k = int'(rand32() % 32'd3);
    inject_mismatch(k);
    exp_cnt[k]++;
    wait_until(WaitResynchReq, "sw_resynch_req_o");
    inject_mismatch(k);
    repeat (2) begin
      @(negedge clk_i);
      #1;
      check_eq("sw_resynch_req_o", sw_resynch_req, 1'b0);
    end
    @(negedge clk_i);
    sp_store_is_zero = 1'b0;
    #1;
    check_eq("setback_o", setback, 3'b111);
    @(negedge clk_i);
    #1;
    check_eq("setback_o", setback, 3'b000);
    check_eq("grp_in_independent_o", grp_in_independent, 1'b0);
    @(negedge clk_i);
    sp_store_is_zero = 1'b1;
    read_check(cnt_addr(k), exp_cnt[k], 1'b0, "mismatch counter");

    // Leave lockstep, then synchronize back in
    write_reg(ADDR_ENABLE, 32'h0);
    #1;
    check_eq("setback_o", setback, 3'b110);
    @(negedge clk_i);
    #1;
    check_eq("grp_in_independent_o", grp_in_independent, 1'b1);
    check_eq("setback_o", setback, 3'b000);
    write_reg(ADDR_ENABLE, 32'h1);
    wait_until(WaitSynchReq, "sw_synch_req_o");
    repeat (3) begin
      @(negedge clk_i);
      #1;
      check_eq("sw_synch_req_o", sw_synch_req, 1'b0);
      check_eq("grp_in_independent_o", grp_in_independent, 1'b1);
    end
    @(negedge clk_i);
    cores_synch = 1'b1;
    #1;
    check_eq("setback_o", setback, 3'b000);
    @(negedge clk_i);
    #1;
    check_eq("setback_o", setback, 3'b111);
    @(negedge clk_i);
    cores_synch = 1'b0;
    wait_until(WaitLockstep, "grp_in_independent_o low");
    @(negedge clk_i);

    // Forced resynchronization
    write_reg(ADDR_CONFIG, 32'h10);
    wait_until(WaitResynchReq, "sw_resynch_req_o");
    read_check(ADDR_CONFIG, 32'h0, 1'b0, "config register");
    @(negedge clk_i);
    sp_store_is_zero = 1'b0;
    @(negedge clk_i);
    sp_store_is_zero = 1'b1;
    for (int j = 0; j < 3; j++) begin
      read_check(cnt_addr(j), exp_cnt[j], 1'b0, "mismatch counter");
    end
    read_check(8'h20, 32'h0, 1'b1, "unmapped register");

    repeat (2) @(negedge clk_i);
    if (i_tmr_subsys_top.i_tmr_assert.fail_cnt == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Regression failed");
      $fatal(1, "Bound assertions fired");
    end
  end

endmodule

`default_nettype wire

//--- tmr_ctrl/tmr_ctrl_fsm.sv
/*
 * TMR mode controller
 * Switches the core group between independent and lockstep execution and
 * sequences recovery, either by state unload and reload or by rapid
 * recovery, after a mismatch or a forced resynchronization.
 */
`default_nettype none

module tmr_ctrl_fsm #(
  parameter bit TmrFixed        = 1'b0,
  parameter bit RapidRecoveryEn = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  tmr_pkg::tmr_cfg_t cfg_i,
  input  logic              single_mismatch_i,
  input  logic              failure_i,
  input  logic [2:0]        error_i,
  input  logic              sp_store_is_zero_i,
  input  logic              sp_store_will_be_zero_i,
  input  logic              fetch_en_i,
  input  logic              cores_synch_i,
  input  logic              recovery_finished_i,
  output logic [2:0]        setback_o,
  output logic              sw_synch_req_o,
  output logic              sw_resynch_req_o,
  output logic              grp_in_independent_o,
  output logic              rapid_recovery_en_o,
  output logic [2:0]        incr_o,
  output logic              recovery_request_o,
  output logic              force_ack_o
);
  import tmr_pkg::*;

  localparam tmr_mode_e ResetMode = TmrFixed ? TMR_RUN : NON_TMR;

  tmr_mode_e mode_d, mode_q;
  logic      synch_req, synch_req_q;
  logic      resynch_req, resynch_req_q;
  logic      cores_synch_q;

  assign grp_in_independent_o = (mode_q == NON_TMR);
  assign rapid_recovery_en_o  = cfg_i.rapid_recovery & RapidRecoveryEn;

  // Requests go out as pulses on their first cycle only
  assign sw_synch_req_o   = synch_req & ~synch_req_q;
  assign sw_resynch_req_o = resynch_req & ~resynch_req_q;

  always_comb begin
    mode_d             = mode_q;
    setback_o          = 3'b000;
    incr_o             = 3'b000;
    recovery_request_o = 1'b0;
    force_ack_o        = 1'b0;
    synch_req          = 1'b0;
    resynch_req        = 1'b0;

    case (mode_q)
      TMR_RUN: begin
        if (single_mismatch_i || cfg_i.force_resynch) begin
          if (single_mismatch_i) begin
            incr_o = error_i;
          end
          force_ack_o = cfg_i.force_resynch;
          if (rapid_recovery_en_o) begin
            mode_d = TMR_RAPID;
          end else if (!cfg_i.delay_resynch) begin
            mode_d = TMR_UNLOAD;
          end
        end
      end

      TMR_UNLOAD: begin
        resynch_req = 1'b1;
        // Store turns nonzero once the state has been unloaded
        if (!sp_store_is_zero_i) begin
          mode_d = TMR_RELOAD;
          if (cfg_i.setback) begin
            setback_o = 3'b111;
          end
        end
      end

      TMR_RELOAD: begin
        if (sp_store_is_zero_i) begin
          mode_d = TMR_RUN;
        end else if ((single_mismatch_i || failure_i) && cfg_i.setback &&
                     cfg_i.reload_setback && !sp_store_will_be_zero_i) begin
          // Restart the reload if the cores diverge again
          setback_o = 3'b111;
        end
      end

      TMR_RAPID: begin
        recovery_request_o = 1'b1;
        if (recovery_finished_i) begin
          mode_d = TMR_RUN;
        end
      end

      default: ;
    endcase

    // Entering and leaving lockstep
    if (!TmrFixed) begin
      if (mode_q == NON_TMR && cfg_i.enable) begin
        synch_req = 1'b1;
        if (cores_synch_q) begin
          mode_d = TMR_RELOAD;
          if (cfg_i.setback) begin
            setback_o = 3'b111;
          end
        end
      end

      // Before the cores fetch, the mode simply follows the enable bit
      if (!fetch_en_i) begin
        if (cfg_i.enable) begin
          mode_d    = TMR_RUN;
          synch_req = 1'b0;
        end else begin
          mode_d = NON_TMR;
        end
      end

      // Leave lockstep, keeping the two helper cores in reset
      if (mode_q == TMR_RUN && !cfg_i.enable) begin
        mode_d = NON_TMR;
        if (cfg_i.setback) begin
          setback_o = 3'b110;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q        <= ResetMode;
      synch_req_q   <= 1'b0;
      resynch_req_q <= 1'b0;
      cores_synch_q <= 1'b0;
    end else begin
      mode_q        <= mode_d;
      synch_req_q   <= synch_req;
      resynch_req_q <= resynch_req;
      cores_synch_q <= cores_synch_i;
    end
  end

endmodule

`default_nettype wire

//--- tmr_ctrl/tmr_ctrl_regs.sv
/*
 * TMR control register file
 * Holds the TMR enable and recovery configuration, returns the mismatch
 * counters on reads and turns counter writes into clear strobes.
 */
`default_nettype none

module tmr_ctrl_regs #(
  parameter bit TmrFixed        = 1'b0,
  parameter bit RapidRecoveryEn = 1'b0,
  parameter int CntWidth        = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  tmr_pkg::reg_req_t            reg_req_i,
  output tmr_pkg::reg_rsp_t            reg_rsp_o,
  input  logic [2:0][CntWidth-1:0]     cnt_i,
  input  logic                         force_ack_i,
  output tmr_pkg::tmr_cfg_t            cfg_o,
  output logic [2:0]                   clr_o
);
  import tmr_pkg::*;

  tmr_cfg_t cfg_q;
  logic     wr_en;
  logic     wr_cfg;

  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  assign wr_cfg = wr_en && (reg_req_i.addr == ADDR_CONFIG);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '{enable: TmrFixed, default: 1'b0};
    end else begin
      if (wr_en && (reg_req_i.addr == ADDR_ENABLE)) begin
        // A fixed group cannot be taken out of TMR
        cfg_q.enable <= reg_req_i.wdata[0] | TmrFixed;
      end
      if (wr_cfg) begin
        cfg_q.delay_resynch  <= reg_req_i.wdata[CFG_DELAY_RESYNCH];
        cfg_q.setback        <= reg_req_i.wdata[CFG_SETBACK];
        cfg_q.reload_setback <= reg_req_i.wdata[CFG_RELOAD_SETBACK];
        cfg_q.rapid_recovery <= reg_req_i.wdata[CFG_RAPID_RECOVERY] & RapidRecoveryEn;
      end
      // Force bit clears itself once the controller has taken it
      if (wr_cfg) begin
        cfg_q.force_resynch <= reg_req_i.wdata[CFG_FORCE_RESYNCH];
      end else if (force_ack_i) begin
        cfg_q.force_resynch <= 1'b0;
      end
    end
  end

  assign cfg_o = cfg_q;

  // Read mux and address decode
  always_comb begin
    reg_rsp_o = '0;
    clr_o     = 3'b000;
    if (reg_req_i.valid) begin
      case (reg_req_i.addr)
        ADDR_ENABLE:    reg_rsp_o.rdata = {31'd0, cfg_q.enable};
        ADDR_CONFIG:    reg_rsp_o.rdata = {27'd0, cfg_q.force_resynch, cfg_q.rapid_recovery,
                                           cfg_q.reload_setback, cfg_q.setback,
                                           cfg_q.delay_resynch};
        ADDR_MISMATCH0: begin
          reg_rsp_o.rdata = 32'(cnt_i[0]);
          clr_o[0]        = reg_req_i.write;
        end
        ADDR_MISMATCH1: begin
          reg_rsp_o.rdata = 32'(cnt_i[1]);
          clr_o[1]        = reg_req_i.write;
        end
        ADDR_MISMATCH2: begin
          reg_rsp_o.rdata = 32'(cnt_i[2]);
          clr_o[2]        = reg_req_i.write;
        end
        default:        reg_rsp_o.error = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire
